// ==== list.f ====
+incdir+common
common/dmac_pkg.sv
common/dmac_row_if.sv
design/dmac_2d_transfer.sv
line_mover/dmac_row_queue.sv
line_mover/dmac_beat_gen.sv
design/dmac_2d_top.sv
tests/tb_dmac_2d.sv

// ==== Makefile ====
# Verilator build and run of the DMA 2D request path testbench

TOP := tb_dmac_2d
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only if the pass line shows up in the output
test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) -f list.f
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ)

// ==== tests/tb_dmac_2d.sv ====
// Testbench for the DMA 2D request path
// Random 2D transfers, a beat model queue, checking assertions and a watchdog

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

module tb_dmac_2d import dmac_pkg::*; ();

  localparam int NUM_XFERS   = 40;
  // Worst case of 4 rows of 6 beats at 8 cycles a beat plus room for sync waits
  localparam int WATCHDOG_NS = NUM_XFERS * 4 * 6 * 8 * 4 + 20000;

  logic       req_aclk;
  logic       req_aresetn;
  logic       req_valid;
  logic       req_ready;
  dmac_addr_t req_dest_address;
  dmac_addr_t req_src_address;
  dmac_len_t  req_x_length;
  dmac_len_t  req_y_length;
  dmac_len_t  req_dest_stride;
  dmac_len_t  req_src_stride;
  logic       req_sync_transfer_start;
  logic       req_eot;
  logic       sync;
  logic       beat_valid;
  logic       beat_ready;
  dmac_addr_t beat_src_address;
  dmac_addr_t beat_dest_address;
  logic       beat_last;

  // Expected beats in acceptance order with one entry per beat
  dmac_addr_t exp_src_q[$];
  dmac_addr_t exp_dest_q[$];
  logic       exp_last_q[$];
  logic       exp_sync_q[$];
  logic       exp_end_q[$];

  int mismatches = 0;
  int others     = 0;
  int req_count  = 0;
  int eot_count  = 0;
  int xfer_done  = 0;

  // Flagged transfers taken whose first beat has not moved yet
  int sync_wait = 0;

  // Cycles after acceptance in which req_ready must still be low
  int ready_low_left = 0;

  // Set by a sync pulse and cleared when a row ends or a flagged transfer is taken
  logic sync_seen = 1'b0;

  dmac_2d_top u_dmac_2d_top (.*);

  initial begin
    req_aclk = 1'b0;
    forever #2 req_aclk = ~req_aclk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      mismatches++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic log_error(input string msg);
    others++;
    $display("Error: %s", msg);
  endtask

  // Row r, beat k sits at the start plus r strides plus k beats
  task automatic queue_expected_beats(input dmac_addr_t src, input dmac_addr_t dest,
                                      input int src_step, input int dest_step,
                                      input int rows, input int beats, input logic sync_flag);
    for (int r = 0; r < rows; r++) begin
      for (int k = 0; k < beats; k++) begin
        exp_src_q.push_back(src + dmac_addr_t'(r * src_step + k));
        exp_dest_q.push_back(dest + dmac_addr_t'(r * dest_step + k));
        exp_last_q.push_back(k == beats - 1);
        exp_sync_q.push_back(sync_flag && r == 0 && k == 0);
        exp_end_q.push_back(r == rows - 1 && k == beats - 1);
      end
    end
  endtask

  task automatic send_request();
    int         gap;
    int         rows;
    int         beats;
    int         src_step;
    int         dest_step;
    logic       sync_flag;
    dmac_addr_t src;
    dmac_addr_t dest;
    gap       = $urandom % 4;
    rows      = 1 + $urandom % 4;
    beats     = 1 + $urandom % 6;
    src_step  = $urandom % 64;
    dest_step = $urandom % 64;
    sync_flag = ($urandom % 2) != 0;
    src       = dmac_addr_t'($urandom);
    dest      = dmac_addr_t'($urandom);
    repeat (gap) @(posedge req_aclk);
    @(posedge req_aclk);
    #1;
    req_valid               = 1'b1;
    req_src_address         = src;
    req_dest_address        = dest;
    req_x_length            = dmac_len_t'((beats << `DMAC_BEAT_WIDTH) - 1);
    req_y_length            = dmac_len_t'(rows - 1);
    req_src_stride          = dmac_len_t'(src_step << `DMAC_BEAT_WIDTH);
    req_dest_stride         = dmac_len_t'(dest_step << `DMAC_BEAT_WIDTH);
    req_sync_transfer_start = sync_flag;
    // The request is taken at the next rising edge where ready is high
    @(negedge req_aclk);
    while (!req_ready) @(negedge req_aclk);
    queue_expected_beats(src, dest, src_step, dest_step, rows, beats, sync_flag);
    req_count++;
    @(posedge req_aclk);
    #1;
    req_valid = 1'b0;
  endtask

  // ******************************************************************
  // Background stimulus
  // ******************************************************************

  initial begin
    forever begin
      @(posedge req_aclk);
      #1;
      beat_ready = ($urandom % 4) != 0;
    end
  end

  initial begin
    forever begin
      repeat (4 + $urandom % 24) @(posedge req_aclk);
      #1;
      sync = 1'b1;
      @(posedge req_aclk);
      #1;
      sync = 1'b0;
    end
  end

  // ******************************************************************
  // Checks
  // ******************************************************************

  // Outputs change only on rising edges so the falling edge sees settled values
  always @(negedge req_aclk) begin
    if (req_aresetn) begin
      if (req_eot) begin
        eot_count++;
        assert (eot_count <= xfer_done) else
          log_error("req_eot pulsed before the last beat of its transfer was accepted");
      end
      if (beat_valid && beat_ready) begin
        if (exp_src_q.size() == 0) begin
          log_error("a beat was accepted while the model expected none");
        end else begin
          // A flagged first row may only start after a sync pulse reached it
          if (exp_sync_q[0]) begin
            assert (sync_seen) else
              log_error("first beat of a sync transfer came before any sync pulse");
            sync_wait--;
          end
          check_value("beat_src_address", 32'(exp_src_q[0]), 32'(beat_src_address));
          check_value("beat_dest_address", 32'(exp_dest_q[0]), 32'(beat_dest_address));
          check_value("beat_last", 32'(exp_last_q[0]), 32'(beat_last));
          if (exp_end_q[0]) xfer_done++;
          void'(exp_src_q.pop_front());
          void'(exp_dest_q.pop_front());
          void'(exp_last_q.pop_front());
          void'(exp_sync_q.pop_front());
          void'(exp_end_q.pop_front());
        end
      end
      if (sync) sync_seen = 1'b1;
      if (beat_valid && beat_ready && beat_last) sync_seen = 1'b0;
      // A flagged row reaches the beat generator only after its request is taken
      if (req_valid && req_ready && req_sync_transfer_start) begin
        if (sync_wait == 0) begin
          sync_seen = 1'b0;
        end
        sync_wait++;
      end
      // Rows issue at most one per cycle after the request is taken
      if (ready_low_left > 0) begin
        if (req_ready) begin
          log_error("req_ready rose before every row of the transfer could be issued");
        end
        ready_low_left--;
      end
      if (req_valid && req_ready) begin
        ready_low_left = int'(req_y_length) + 1;
      end
    end
  end

  a_beat_hold: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat_src_address) &&
      $stable(beat_dest_address) && $stable(beat_last)
  ) else log_error("beat outputs changed while beat_ready was low");

  a_ready_drop: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    req_valid && req_ready |=> !req_ready
  ) else log_error("req_ready stayed high after a request was accepted");

  a_eot_pulse: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    req_eot |=> !req_eot
  ) else log_error("req_eot was high for more than one cycle");

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d transfers complete",
             WATCHDOG_NS, eot_count, NUM_XFERS);
    $display("Summary: %0d value mismatches, %0d other errors", mismatches, others);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h0bc30189));
    req_aresetn             = 1'b0;
    req_valid               = 1'b0;
    req_dest_address        = '0;
    req_src_address         = '0;
    req_x_length            = '0;
    req_y_length            = '0;
    req_dest_stride         = '0;
    req_src_stride          = '0;
    req_sync_transfer_start = 1'b0;
    sync                    = 1'b0;
    beat_ready              = 1'b0;
    repeat (5) @(posedge req_aclk);
    #1;
    req_aresetn = 1'b1;
    @(negedge req_aclk);
    check_value("req_ready_after_reset", 32'(1'b1), 32'(req_ready));
    check_value("beat_valid_after_reset", 32'(1'b0), 32'(beat_valid));
    check_value("req_eot_after_reset", 32'(1'b0), 32'(req_eot));
    for (int i = 0; i < NUM_XFERS; i++) begin
      send_request();
    end
    wait (eot_count >= NUM_XFERS);
    repeat (20) @(posedge req_aclk);
    check_value("req_eot_count", 32'(req_count), 32'(eot_count));
    check_value("beats_left_in_model", 32'(0), 32'(exp_src_q.size()));
    $display("Summary: %0d value mismatches, %0d other errors", mismatches, others);
    if (mismatches == 0 && others == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/dmac_2d_top.sv ====
// Top level of the DMA 2D request path
// 2D splitter, row queue and beat generator

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

module dmac_2d_top import dmac_pkg::*; (
  input  wire        req_aclk,
  input  wire        req_aresetn,

  // 2D request
  input  wire        req_valid,
  output logic       req_ready,
  input  dmac_addr_t req_dest_address,
  input  dmac_addr_t req_src_address,
  input  dmac_len_t  req_x_length,
  input  dmac_len_t  req_y_length,
  input  dmac_len_t  req_dest_stride,
  input  dmac_len_t  req_src_stride,
  input  wire        req_sync_transfer_start,
  output logic       req_eot,

  // External start pulse for flagged rows
  input  wire        sync,

  // Beat address stream
  output logic       beat_valid,
  input  wire        beat_ready,
  output dmac_addr_t beat_src_address,
  output dmac_addr_t beat_dest_address,
  output logic       beat_last
);

  dmac_row_if row_if ();

  // Queue head as seen by the beat generator
  logic       head_valid;
  dmac_addr_t head_dest_address;
  dmac_addr_t head_src_address;
  dmac_len_t  head_length;
  logic       head_sync;
  logic       pop;
  logic       row_eot;

  dmac_2d_transfer u_2d (
    .req_aclk                (req_aclk),
    .req_aresetn             (req_aresetn),
    .req_valid               (req_valid),
    .req_ready               (req_ready),
    .req_dest_address        (req_dest_address),
    .req_src_address         (req_src_address),
    .req_x_length            (req_x_length),
    .req_y_length            (req_y_length),
    .req_dest_stride         (req_dest_stride),
    .req_src_stride          (req_src_stride),
    .req_sync_transfer_start (req_sync_transfer_start),
    .req_eot                 (req_eot),
    .row                     (row_if.source)
  );

  dmac_row_queue u_queue (
    .req_aclk          (req_aclk),
    .req_aresetn       (req_aresetn),
    .row               (row_if.sink),
    .head_valid        (head_valid),
    .head_dest_address (head_dest_address),
    .head_src_address  (head_src_address),
    .head_length       (head_length),
    .head_sync         (head_sync),
    .pop               (pop),
    .row_eot           (row_eot)
  );

  dmac_beat_gen u_beat (
    .req_aclk          (req_aclk),
    .req_aresetn       (req_aresetn),
    .head_valid        (head_valid),
    .head_dest_address (head_dest_address),
    .head_src_address  (head_src_address),
    .head_length       (head_length),
    .head_sync         (head_sync),
    .pop               (pop),
    .row_eot           (row_eot),
    .sync              (sync),
    .beat_valid        (beat_valid),
    .beat_ready        (beat_ready),
    .beat_src_address  (beat_src_address),
    .beat_dest_address (beat_dest_address),
    .beat_last         (beat_last)
  );

endmodule

`default_nettype wire

// ==== line_mover/dmac_beat_gen.sv ====
// Beat generator of the line mover
// Turns queued rows into beat addresses, with sync wait and row completion

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

module dmac_beat_gen import dmac_pkg::*; (
  input  wire        req_aclk,
  input  wire        req_aresetn,

  input  wire        head_valid,
  input  dmac_addr_t head_dest_address,
  input  dmac_addr_t head_src_address,
  input  dmac_len_t  head_length,
  input  wire        head_sync,
  output logic       pop,
  output logic       row_eot,

  input  wire        sync,

  output logic       beat_valid,
  input  wire        beat_ready,
  output dmac_addr_t beat_src_address,
  output dmac_addr_t beat_dest_address,
  output logic       beat_last
);

  dmac_beat_state_t state;

  // Address of the beat on offer
  dmac_addr_t src_address;
  dmac_addr_t dest_address;

  // Beats left in the row after the one on offer
  logic [`DMAC_BEATS_WIDTH-1:0] beat_cnt;

  logic beat_accept;

  // A row is taken from the head on any idle cycle where one is waiting
  assign pop        = (state == st_idle) && head_valid;

  assign beat_valid        = state == st_run;
  assign beat_accept       = beat_valid && beat_ready;
  assign beat_src_address  = src_address;
  assign beat_dest_address = dest_address;
  assign beat_last         = beat_cnt == '0;

  // ********************************************************************
  // Row walk
  // ********************************************************************

  // Address and count registers load from the head on pop and step per accepted beat
  always_ff @(posedge req_aclk) begin
    if (pop) begin
      src_address  <= head_src_address;
      dest_address <= head_dest_address;
      // Length is bytes minus one so dropping the beat bits gives beats minus one
      beat_cnt     <= head_length[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH];
    end else if (beat_accept) begin
      src_address  <= src_address + dmac_addr_t'(1);
      dest_address <= dest_address + dmac_addr_t'(1);
      beat_cnt     <= beat_cnt - (`DMAC_BEATS_WIDTH)'(1);
    end
  end

  always_ff @(posedge req_aclk) begin
    if (!req_aresetn) begin
      state   <= st_idle;
      row_eot <= 1'b0;
    end else begin
      // Completion is reported on the cycle after the last beat moves
      row_eot <= beat_accept && beat_last;
      unique case (state)
        st_idle: begin
          if (head_valid) begin
            state <= head_sync ? st_wait_sync : st_run;
          end
        end
        st_wait_sync: begin
          // Only a pulse seen after the row arrived releases it
          if (sync) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (beat_accept && beat_last) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // A beat on offer keeps its address and last flag until it is taken
  a_beat_stable: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat_src_address) &&
      $stable(beat_dest_address) && $stable(beat_last)
  );

endmodule

`default_nettype wire

// ==== line_mover/dmac_row_queue.sv ====
// Row request FIFO of the line mover
// Holds each row from acceptance until its completion comes back

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

module dmac_row_queue import dmac_pkg::*; (
  input  wire        req_aclk,
  input  wire        req_aresetn,

  dmac_row_if.sink   row,

  output logic       head_valid,
  output dmac_addr_t head_dest_address,
  output dmac_addr_t head_src_address,
  output dmac_len_t  head_length,
  output logic       head_sync,
  input  wire        pop,
  input  wire        row_eot
);

  // Entry storage is written on push and read at the head
  dmac_addr_t dest_mem [`DMAC_QUEUE_DEPTH];
  dmac_addr_t src_mem [`DMAC_QUEUE_DEPTH];
  dmac_len_t  len_mem [`DMAC_QUEUE_DEPTH];
  logic       sync_mem [`DMAC_QUEUE_DEPTH];

  dmac_id_t wr_ptr;
  dmac_id_t rd_ptr;

  // Pending counts the rows not yet popped
  // Held counts the rows not yet completed
  // A slot only frees on completion so the row ids never alias
  logic [`DMAC_ID_WIDTH:0] pend_cnt;
  logic [`DMAC_ID_WIDTH:0] held_cnt;

  logic push;

  assign push       = row.valid && row.ready;
  assign row.ready  = held_cnt < (`DMAC_ID_WIDTH+1)'(`DMAC_QUEUE_DEPTH);
  assign row.eot    = row_eot;

  assign head_valid        = pend_cnt != '0;
  assign head_dest_address = dest_mem[rd_ptr];
  assign head_src_address  = src_mem[rd_ptr];
  assign head_length       = len_mem[rd_ptr];
  assign head_sync         = sync_mem[rd_ptr];

  always_ff @(posedge req_aclk) begin
    if (push) begin
      dest_mem[wr_ptr] <= row.dest_address;
      src_mem[wr_ptr]  <= row.src_address;
      len_mem[wr_ptr]  <= row.length;
      sync_mem[wr_ptr] <= row.sync;
    end
  end

  always_ff @(posedge req_aclk) begin
    if (!req_aresetn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      pend_cnt <= '0;
      held_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + dmac_id_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + dmac_id_t'(1);
      end
      if (push && !pop) begin
        pend_cnt <= pend_cnt + (`DMAC_ID_WIDTH+1)'(1);
      end else if (!push && pop) begin
        pend_cnt <= pend_cnt - (`DMAC_ID_WIDTH+1)'(1);
      end
      if (push && !row_eot) begin
        held_cnt <= held_cnt + (`DMAC_ID_WIDTH+1)'(1);
      end else if (!push && row_eot) begin
        held_cnt <= held_cnt - (`DMAC_ID_WIDTH+1)'(1);
      end
    end
  end

  // The beat generator must only take a row that is there
  a_no_pop_empty: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn) pop |-> pend_cnt != '0
  );

  // A push must land in a storage slot that the beat generator has already popped
  a_no_push_full: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    push |-> pend_cnt < (`DMAC_ID_WIDTH+1)'(`DMAC_QUEUE_DEPTH)
  );

endmodule

`default_nettype wire

// ==== design/dmac_2d_transfer.sv ====
// 2D transfer splitter
// Breaks one 2D request into strided rows and signals the end of the transfer

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

module dmac_2d_transfer import dmac_pkg::*; (
  input  wire        req_aclk,
  input  wire        req_aresetn,

  input  wire        req_valid,
  output logic       req_ready,
  input  dmac_addr_t req_dest_address,
  input  dmac_addr_t req_src_address,
  input  dmac_len_t  req_x_length,
  input  dmac_len_t  req_y_length,
  input  dmac_len_t  req_dest_stride,
  input  dmac_len_t  req_src_stride,
  input  wire        req_sync_transfer_start,
  output logic       req_eot,

  dmac_row_if.source row
);

  // Current row addresses and the number of rows still to issue minus one
  dmac_addr_t dest_address;
  dmac_addr_t src_address;
  dmac_len_t  x_length;
  dmac_len_t  y_length;
  dmac_len_t  dest_stride;
  dmac_len_t  src_stride;

  // Ids of the next row to issue and the next row to complete
  dmac_id_t   req_id;
  dmac_id_t   eot_id;

  // One flag per id slot that is set when that row closes its transfer
  logic [`DMAC_QUEUE_DEPTH-1:0] last_req;

  // Rows issued but not yet completed
  logic [`DMAC_ID_WIDTH:0] rows_out;

  logic row_accept;

  assign row_accept       = row.valid && row.ready;

  assign row.dest_address = dest_address;
  assign row.src_address  = src_address;
  assign row.length       = x_length;

  // ********************************************************************
  // Completion tracking
  // ********************************************************************

  // Each accepted row records whether it closes its transfer
  always_ff @(posedge req_aclk) begin
    if (row_accept) begin
      last_req[req_id] <= (y_length == '0);
    end
  end

  always_ff @(posedge req_aclk) begin
    if (!req_aresetn) begin
      req_id   <= '0;
      eot_id   <= '0;
      rows_out <= '0;
      req_eot  <= 1'b0;
    end else begin
      if (row_accept) begin
        req_id <= req_id + dmac_id_t'(1);
      end
      // Completions arrive in issue order so a second counter finds the slot
      req_eot <= 1'b0;
      if (row.eot) begin
        eot_id  <= eot_id + dmac_id_t'(1);
        req_eot <= last_req[eot_id];
      end
      if (row_accept && !row.eot) begin
        rows_out <= rows_out + (`DMAC_ID_WIDTH+1)'(1);
      end else if (!row_accept && row.eot) begin
        rows_out <= rows_out - (`DMAC_ID_WIDTH+1)'(1);
      end
    end
  end

  // ********************************************************************
  // Row issue
  // ********************************************************************

  // The request fields load when a request is taken and step on each accepted row
  always_ff @(posedge req_aclk) begin
    if (req_ready && req_valid) begin
      dest_address <= req_dest_address;
      src_address  <= req_src_address;
      x_length     <= req_x_length;
      y_length     <= req_y_length;
      dest_stride  <= req_dest_stride;
      src_stride   <= req_src_stride;
    end else if (!req_ready && row_accept) begin
      // Strides are in bytes while the addresses move in whole beats
      dest_address <= dest_address +
                      dmac_addr_t'(dest_stride[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH]);
      src_address  <= src_address +
                      dmac_addr_t'(src_stride[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH]);
      y_length     <= y_length - dmac_len_t'(1);
    end
  end

  always_ff @(posedge req_aclk) begin
    if (!req_aresetn) begin
      req_ready <= 1'b1;
      row.valid <= 1'b0;
      row.sync  <= 1'b0;
    end else if (req_ready) begin
      if (req_valid) begin
        req_ready <= 1'b0;
        row.valid <= 1'b1;
        row.sync  <= req_sync_transfer_start;
      end
    end else if (row_accept) begin
      // Only the first row of a transfer waits for sync
      row.sync <= 1'b0;
      if (y_length == '0) begin
        row.valid <= 1'b0;
        req_ready <= 1'b1;
      end
    end
  end

  // A stalled row keeps its fields until the queue takes it
  a_row_stable: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    row.valid && !row.ready |=> row.valid && $stable(row.dest_address) &&
      $stable(row.src_address) && $stable(row.length) && $stable(row.sync)
  );

  // A transfer can only end on the completion of a row that was issued
  a_eot_outstanding: assert property (
    @(posedge req_aclk) disable iff (!req_aresetn)
    req_eot |-> $past(rows_out) != '0
  );

endmodule

`default_nettype wire

// ==== common/dmac_row_if.sv ====
// Row request channel between the 2D block and the line mover
// One row request with a valid/ready handshake and its completion pulse

`timescale 1ns/100ps
`default_nettype none

`include "dmac_macros.svh"

interface dmac_row_if import dmac_pkg::*; ();

  // Handshake, a row moves on a clock where both are high
  logic       valid;
  logic       ready;

  // Row fields, start addresses in beats and the row length in bytes minus one
  dmac_addr_t dest_address;
  dmac_addr_t src_address;
  dmac_len_t  length;

  // Set on a row that has to wait for the external sync pulse
  logic       sync;

  // One pulse per completed row, in the order the rows were accepted
  logic       eot;

  // The 2D block issues rows and sees their completion
  modport source (
    output valid,
    output dest_address,
    output src_address,
    output length,
    output sync,
    input  ready,
    input  eot
  );

  // The row queue accepts rows and returns the completion from the mover
  modport sink (
    input  valid,
    input  dest_address,
    input  src_address,
    input  length,
    input  sync,
    output ready,
    output eot
  );

endinterface

`default_nettype wire

// ==== common/dmac_pkg.sv ====
// Types for the DMA 2D request path
// Address, length and row id vectors, beat generator states

`default_nettype none

`include "dmac_macros.svh"

package dmac_pkg;

  // ********************************************************************
  // Vector types
  // ********************************************************************

  // Beat address, a byte address with the low beat bits removed
  typedef logic [`DMAC_ADDR_WIDTH-1:0] dmac_addr_t;

  // Byte length minus one, row count minus one, or a stride in bytes
  typedef logic [`DMAC_LENGTH_WIDTH-1:0] dmac_len_t;

  // Id of an issued or a completed row
  // Issue and completion each keep their own counter of this type
  typedef logic [`DMAC_ID_WIDTH-1:0] dmac_id_t;

  // ********************************************************************
  // Beat generator FSM
  // ********************************************************************

  // Idle takes the next row from the queue head
  // Wait_sync holds a flagged row until the sync pulse
  // Run emits the beats of the current row
  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_wait_sync = 2'd1,
    st_run       = 2'd2
  } dmac_beat_state_t;

endpackage

`default_nettype wire

// ==== common/dmac_macros.svh ====
// Width and depth macros shared by the DMA 2D request path
// Lengths, beat size and row queue depth

`ifndef DMAC_MACROS_SVH
`define DMAC_MACROS_SVH

// Width of byte lengths, row counts and strides
`define DMAC_LENGTH_WIDTH 24

// Log2 of the bytes moved per beat, used on both source and destination
`define DMAC_BEAT_WIDTH 3

// Byte addresses are 32 bits wide and beat addresses drop the low bits
`define DMAC_ADDR_WIDTH (32 - `DMAC_BEAT_WIDTH)

// Number of rows the line mover may hold between issue and completion
`define DMAC_QUEUE_DEPTH 4

// Row id width, log2 of the queue depth
// The ids wrap exactly once per full queue, so the two must agree
`define DMAC_ID_WIDTH 2

// Width of a count of beats in one row, minus one
`define DMAC_BEATS_WIDTH (`DMAC_LENGTH_WIDTH - `DMAC_BEAT_WIDTH)

`endif
